// ==== src/invaders_io_defs.svh ====
// invaders i/o shared constants
`ifndef INVADERS_IO_DEFS_SVH
`define INVADERS_IO_DEFS_SVH

// cpu side i/o bus
`define IO_DATA_W 8
`define IO_PORT_W 3

// mb14241 shifter
`define SHIFT_REG_W 16
`define SHIFT_AMT_W 3

// sound port latches and serial frame
`define SND1_W 6
`define SND2_W 5
`define SX_FRAME_W 16

// video counters, both 9 bits with a skip in the middle
`define H_COUNT_W 9
`define V_COUNT_W 9
`define H_ACTIVE_END 255
`define H_BLANK_START 448
`define V_ACTIVE_START 32
`define V_ACTIVE_END 255
`define V_BLANK_START 474

`endif

// ==== src/invaders_io_pkg.sv ====
// invaders i/o types
`include "invaders_io_defs.svh"

package invaders_io_pkg;

	// write port numbers as seen on the i/o bus
	typedef enum logic [`IO_PORT_W-1:0] {
		IO_SHIFT_AMT  = 3'd2,
		IO_SOUND1     = 3'd3,
		IO_SHIFT_DATA = 3'd4,
		IO_SOUND2     = 3'd5
	} io_port_e;

	// read ports, only two address bits decoded
	typedef enum logic [1:0] {
		RD_INP0  = 2'd0,
		RD_INP1  = 2'd1,
		RD_INP2  = 2'd2,
		RD_SHIFT = 2'd3
	} io_rd_sel_e;

	// plain strobed write bus
	typedef struct packed {
		logic [`IO_PORT_W-1:0] port;
		logic [`IO_DATA_W-1:0] wdata;
		logic                  wr;
	} cpu_io_t;

	// cabinet pins, all active low
	typedef struct packed {
		logic left_n;
		logic right_n;
		logic fire_n;
		logic start_n;
		logic coin_n;
	} cabinet_t;

	typedef struct packed {
		logic dip7;
		logic dip6;
		logic dip5;
		logic dip4;
		logic dip3;
	} dip_t;

	// snd1 from port 3, snd2 from port 5
	typedef struct packed {
		logic [`SND1_W-1:0] snd1;
		logic [`SND2_W-1:0] snd2;
	} sound_latch_t;

	typedef struct packed {
		logic [7:0] hcount;
		logic [7:0] vcount;
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
	} video_t;

endpackage

// ==== src/video_timing.sv ====
// video sync generator
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module video_timing (
	input  logic                   clk,
	input  logic                   rst_n,
	output invaders_io_pkg::video_t video
);

	// full 9-bit counters, bit 8 doubles as blanking
	logic [`H_COUNT_W-1:0] h_cnt;
	logic [`V_COUNT_W-1:0] v_cnt;
	logic                  line_end;

	// vertical step once per line, at start of hblank region
	assign line_end = (h_cnt == `H_COUNT_W'(`H_BLANK_START));

	// 0..255 then 448..511, wraps to 0 by overflow
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			h_cnt <= '0;
		else if (h_cnt == `H_COUNT_W'(`H_ACTIVE_END))
			h_cnt <= `H_COUNT_W'(`H_BLANK_START);
		else
			h_cnt <= h_cnt + 1'b1;
	end

	// 32..255 then 474..511, back to 32
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			v_cnt <= `V_COUNT_W'(`V_ACTIVE_START);
		else if (line_end)
		begin
			if (v_cnt == `V_COUNT_W'(`V_ACTIVE_END))
				v_cnt <= `V_COUNT_W'(`V_BLANK_START);
			else if (&v_cnt)
				v_cnt <= `V_COUNT_W'(`V_ACTIVE_START);
			else
				v_cnt <= v_cnt + 1'b1;
		end
	end

	always_comb
	begin
		video.hcount = h_cnt[7:0];
		video.vcount = v_cnt[7:0];
		video.hblank = h_cnt[8];
		video.vblank = v_cnt[8];
		// hsync inside hblank, 16 counts wide
		video.hsync  = h_cnt[8] & ~h_cnt[5] & h_cnt[4];
		// vsync on lines with 8V and 4V set, 16V clear
		video.vsync  = v_cnt[8] & v_cnt[3] & v_cnt[2] & ~v_cnt[4];
	end

endmodule

// ==== src/io_port_regs.sv ====
// i/o write decoder
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module io_port_regs (
	input  logic                          clk,
	input  logic                          rst_n,
	input  invaders_io_pkg::cpu_io_t      io,
	output logic [`SHIFT_AMT_W-1:0]       shift_amt,
	output logic                          shift_load,
	output logic [`IO_DATA_W-1:0]         shift_in,
	output invaders_io_pkg::sound_latch_t sound
);

	import invaders_io_pkg::*;

	io_port_e wr_port;
	logic     data_wr;

	assign wr_port = io_port_e'(io.port);
	// port 4 write feeds the shifter
	assign data_wr = io.wr && (wr_port == IO_SHIFT_DATA);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shift_amt  <= '0;
			shift_load <= 1'b0;
			sound      <= '0;
		end
		else
		begin
			// load strobe lasts one cycle only
			shift_load <= data_wr;
			if (io.wr)
			begin
				case (wr_port)
					IO_SHIFT_AMT:
						shift_amt <= io.wdata[`SHIFT_AMT_W-1:0];
					IO_SOUND1:
						sound.snd1 <= io.wdata[`SND1_W-1:0];
					IO_SOUND2:
						sound.snd2 <= io.wdata[`SND2_W-1:0];
					// ports 0, 1, 4, 6, 7 leave these alone
					default:
					begin
					end
				endcase
			end
		end
	end

	// data byte held alongside the load strobe
	always_ff @(posedge clk)
	begin
		if (data_wr)
			shift_in <= io.wdata;
	end

endmodule

// ==== src/mb14241_shifter.sv ====
// mb14241 barrel shifter
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module mb14241_shifter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    shift_load,
	input  logic [`IO_DATA_W-1:0]   shift_in,
	input  logic [`SHIFT_AMT_W-1:0] shift_amt,
	output logic [`IO_DATA_W-1:0]   shift_out
);

	logic [`SHIFT_REG_W-1:0] sh_reg;
	logic [`SHIFT_REG_W-1:0] sh_win;

	// new byte enters at the top, old top drops to the bottom
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sh_reg <= '0;
		else if (shift_load)
			sh_reg <= {shift_in, sh_reg[`SHIFT_REG_W-1:`IO_DATA_W]};
	end

	// window slides down by amt bits
	// result is bits 15-amt .. 8-amt
	always_comb
	begin
		sh_win    = sh_reg << shift_amt;
		shift_out = sh_win[`SHIFT_REG_W-1:`IO_DATA_W];
	end

endmodule

// ==== src/input_port_mux.sv ====
// cabinet input read mux
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module input_port_mux (
	input  logic [1:0]               port,
	input  invaders_io_pkg::cabinet_t cab,
	input  invaders_io_pkg::dip_t    dip,
	input  logic [`IO_DATA_W-1:0]    shift_out,
	output logic [`IO_DATA_W-1:0]    rd_data
);

	import invaders_io_pkg::*;

	// pins come in active low
	logic right;
	logic left;
	logic fire;
	logic start;
	logic coin;

	assign right = ~cab.right_n;
	assign left  = ~cab.left_n;
	assign fire  = ~cab.fire_n;
	assign start = ~cab.start_n;
	assign coin  = ~cab.coin_n;

	// upper port bit ignored, so 4..7 alias 0..3
	always_comb
	begin
		case (io_rd_sel_e'(port))
			RD_INP0:  rd_data = {1'b0, right, left, fire, 3'b111, dip.dip4};
			// start feeds both player start bits
			RD_INP1:  rd_data = {1'b0, right, left, fire, 1'b1, start, start, coin};
			// tilt bit tied low
			RD_INP2:  rd_data = {dip.dip7, right, left, fire, dip.dip6, 1'b0,
				dip.dip5, dip.dip3};
			default:  rd_data = shift_out;
		endcase
	end

endmodule

// ==== src/sound_serializer.sv ====
// sound port serial output
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module sound_serializer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  invaders_io_pkg::sound_latch_t sound,
	input  invaders_io_pkg::video_t       video,
	output logic                          sx_data,
	output logic                          sx_rclk
);

	logic [`SX_FRAME_W-1:0] frame;
	logic [3:0]             bit_sel;

	// msb first out of the 595 chain
	// snd1 bit 0 goes out inverted, snd1 bits 5:4 not carried
	assign frame = {6'b0, sound.snd2, 1'b0, sound.snd1[3:1], ~sound.snd1[0]};

	// 16H..1H walk the frame from bit 15 down
	assign bit_sel = ~video.hcount[3:0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sx_data <= 1'b0;
			sx_rclk <= 1'b0;
		end
		else
		begin
			sx_data <= frame[bit_sel];
			// latch pulse at start of each 16 count group
			sx_rclk <= (video.hcount[3:0] == 4'd0);
		end
	end

endmodule

// ==== src/invaders_io_top.sv ====
// invaders i/o board top
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module invaders_io_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  invaders_io_pkg::cpu_io_t      io,
	output logic [`IO_DATA_W-1:0]         rd_data,
	input  invaders_io_pkg::cabinet_t     cab,
	input  invaders_io_pkg::dip_t         dip,
	output invaders_io_pkg::sound_latch_t sound,
	output invaders_io_pkg::video_t       video,
	output logic                          csync,
	output logic                          sx_data,
	output logic                          sx_rclk
);

	// shifter config from the write decoder
	logic [`SHIFT_AMT_W-1:0] shift_amt;
	logic                    shift_load;
	logic [`IO_DATA_W-1:0]   shift_in;
	logic [`IO_DATA_W-1:0]   shift_out;

	video_timing i_video_timing (
		.clk   (clk),
		.rst_n (rst_n),
		.video (video)
	);

	io_port_regs i_io_port_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.io         (io),
		.shift_amt  (shift_amt),
		.shift_load (shift_load),
		.shift_in   (shift_in),
		.sound      (sound)
	);

	mb14241_shifter i_mb14241_shifter (
		.clk        (clk),
		.rst_n      (rst_n),
		.shift_load (shift_load),
		.shift_in   (shift_in),
		.shift_amt  (shift_amt),
		.shift_out  (shift_out)
	);

	// reads decode only the low two port bits
	input_port_mux i_input_port_mux (
		.port      (io.port[1:0]),
		.cab       (cab),
		.dip       (dip),
		.shift_out (shift_out),
		.rd_data   (rd_data)
	);

	sound_serializer i_sound_serializer (
		.clk     (clk),
		.rst_n   (rst_n),
		.sound   (sound),
		.video   (video),
		.sx_data (sx_data),
		.sx_rclk (sx_rclk)
	);

	// composite sync, low during either sync
	assign csync = ~(video.hsync | video.vsync);

endmodule

// ==== tb/invaders_io_props.sv ====
// video timing assertions
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module invaders_io_props (
	input logic                    clk,
	input logic                    rst_n,
	input logic [`H_COUNT_W-1:0]   h_cnt,
	input logic [`V_COUNT_W-1:0]   v_cnt,
	input invaders_io_pkg::video_t video
);

	import invaders_io_pkg::*;

	// sync pulses sit inside the blanking counts past the skip
	hsync_in_hblank: assert property (@(posedge clk) disable iff (!rst_n)
		video.hsync |-> (h_cnt >= `H_BLANK_START))
		else $error("hsync outside hblank");

	vsync_in_vblank: assert property (@(posedge clk) disable iff (!rst_n)
		video.vsync |-> (v_cnt >= `V_BLANK_START))
		else $error("vsync outside vblank");

	// active part of a line is 256 counts
	hblank_period: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(video.hblank) |-> ##256 $rose(video.hblank))
		else $error("hblank low period not 256 cycles");

	// skipped range of the horizontal counter
	h_cnt_skip: assert property (@(posedge clk) disable iff (!rst_n)
		(h_cnt <= `H_ACTIVE_END) || (h_cnt >= `H_BLANK_START))
		else $error("hcount inside skipped range");

endmodule

bind video_timing invaders_io_props i_invaders_io_props (
	.clk   (clk),
	.rst_n (rst_n),
	.h_cnt (h_cnt),
	.v_cnt (v_cnt),
	.video (video)
);

// ==== tb/invaders_io_tb.sv ====
// invaders i/o testbench
`timescale 1ns/1ps
`include "invaders_io_defs.svh"

module invaders_io_tb;

	import invaders_io_pkg::*;

	localparam int FRAME_CYCLES = 262 * 320;
	localparam int WATCHDOG_CYCLES = 2 * FRAME_CYCLES + 2000;

	logic         clk;
	logic         rst_n;
	cpu_io_t      io;
	cabinet_t     cab;
	dip_t         dip;
	logic [7:0]   rd_data;
	sound_latch_t sound;
	video_t       video;
	logic         csync;
	logic         sx_data;
	logic         sx_rclk;

	// reference state
	logic [15:0]  lfsr;
	logic [15:0]  ref_reg;
	logic [2:0]   ref_amt;
	logic [5:0]   ref_snd1;
	logic [4:0]   ref_snd2;
	logic [8:0]   ref_h;
	logic [8:0]   ref_v;
	logic [7:0]   prev_h;
	sound_latch_t prev_snd;
	logic         prev_ok;
	int           errors;

	invaders_io_top i_invaders_io_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.io      (io),
		.rd_data (rd_data),
		.cab     (cab),
		.dip     (dip),
		.sound   (sound),
		.video   (video),
		.csync   (csync),
		.sx_data (sx_data),
		.sx_rclk (sx_rclk)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// upper byte of the register after a left shift by amt
	function automatic logic [7:0] shift_window(input logic [15:0] r, input logic [2:0] amt);
		logic [23:0] wide;
		wide = {8'h00, r} << amt;
		return wide[15:8];
	endfunction

	function automatic logic [7:0] read_byte(input logic [2:0] p, input cabinet_t c,
		input dip_t d, input logic [7:0] sh);
		logic r;
		logic l;
		logic f;
		r = !c.right_n;
		l = !c.left_n;
		f = !c.fire_n;
		case (p % 4)
			0: return {1'b0, r, l, f, 1'b1, 1'b1, 1'b1, d.dip4};
			1: return {1'b0, r, l, f, 1'b1, !c.start_n, !c.start_n, !c.coin_n};
			2: return {d.dip7, r, l, f, d.dip6, 1'b0, d.dip5, d.dip3};
			default: return sh;
		endcase
	endfunction

	// frame bit number 15 minus the low hcount bits
	function automatic logic frame_bit(input sound_latch_t s, input logic [7:0] h);
		int idx;
		idx = 15 - int'(h[3:0]);
		if (idx >= 10 || idx == 4)
			return 1'b0;
		else if (idx >= 5)
			return s.snd2[idx-5];
		else if (idx >= 1)
			return s.snd1[idx];
		else
			return !s.snd1[0];
	endfunction

	function automatic logic [8:0] next_h(input logic [8:0] h);
		return (h == 9'd255) ? 9'd448 : h + 9'd1;
	endfunction

	function automatic logic [8:0] next_v(input logic [8:0] v);
		if (v == 9'd255)
			return 9'd474;
		else if (v == 9'd511)
			return 9'd32;
		else
			return v + 9'd1;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// counter model runs beside the dut
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			ref_h <= next_h(ref_h);
			if (ref_h == 9'd448)
				ref_v <= next_v(ref_v);
		end
	end

	// video, csync and serial output compared every cycle
	always @(negedge clk)
	begin
		logic exp_hs;
		logic exp_vs;
		if (rst_n)
		begin
			exp_hs = ref_h[8] & !ref_h[5] & ref_h[4];
			exp_vs = ref_v[8] & ref_v[3] & ref_v[2] & !ref_v[4];
			check(video.hcount, ref_h[7:0], "hcount");
			check(video.vcount, ref_v[7:0], "vcount");
			check(video.hblank, ref_h[8], "hblank");
			check(video.vblank, ref_v[8], "vblank");
			check(video.hsync, exp_hs, "hsync");
			check(video.vsync, exp_vs, "vsync");
			check(csync, !(exp_hs | exp_vs), "csync");
			if (prev_ok)
			begin
				check(sx_data, frame_bit(prev_snd, prev_h), "sx_data");
				check(sx_rclk, prev_h[3:0] == 4'd0, "sx_rclk");
			end
			prev_h   = video.hcount;
			prev_snd = sound;
			prev_ok  = 1'b1;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 8);
		$display(">>> FAIL");
		$fatal(1, "watchdog timeout, tests did not finish in time");
	end

	initial
	begin
		logic [15:0] r;
		logic [2:0]  p;
		logic [7:0]  d;
		int          pulses;
		logic [2:0]  snd_ports [6];

		snd_ports = '{3'd3, 3'd5, 3'd0, 3'd1, 3'd6, 3'd7};
		io       = '0;
		cab      = '1;
		dip      = '0;
		rst_n    = 1'b0;
		lfsr     = 16'd67;
		ref_reg  = '0;
		ref_amt  = '0;
		ref_snd1 = '0;
		ref_snd2 = '0;
		ref_h    = 9'd0;
		ref_v    = 9'd32;
		prev_ok  = 1'b0;
		errors   = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// reset values
		@(negedge clk);
		check(sound, '0, "sound after reset");
		check(sx_rclk, 1'b0, "sx_rclk after reset");
		check(csync, 1'b1, "csync after reset");

		// shifter with random amount and data writes
		for (int i = 0; i < 40; i++)
		begin
			rand_bits(1, r);
			p = r[0] ? 3'd4 : 3'd2;
			rand_bits(8, r);
			d = r[7:0];
			@(posedge clk);
			io <= '{port: p, wdata: d, wr: 1'b1};
			if (p == 3'd4)
				ref_reg = {d, ref_reg[15:8]};
			else
				ref_amt = d[2:0];
			@(posedge clk);
			io <= '{port: 3'd3, wdata: 8'h00, wr: 1'b0};
			@(posedge clk);
			@(negedge clk);
			check(rd_data, shift_window(ref_reg, ref_amt), "shifter read");
		end

		// input ports with aliasing
		for (int i = 0; i < 32; i++)
		begin
			rand_bits(5, r);
			@(posedge clk);
			cab <= cabinet_t'(r[4:0]);
			rand_bits(5, r);
			dip <= dip_t'(r[4:0]);
			io  <= '{port: 3'(i), wdata: 8'h00, wr: 1'b0};
			@(negedge clk);
			check(rd_data, read_byte(3'(i), cab, dip, shift_window(ref_reg, ref_amt)),
				"input port read");
		end

		// sound latches, other ports ignored
		for (int i = 0; i < 30; i++)
		begin
			rand_bits(8, r);
			d = r[7:0];
			p = snd_ports[i % 6];
			@(posedge clk);
			io <= '{port: p, wdata: d, wr: 1'b1};
			if (p == 3'd3)
				ref_snd1 = d[5:0];
			else if (p == 3'd5)
				ref_snd2 = d[4:0];
			@(posedge clk);
			io <= '{port: 3'd0, wdata: 8'h00, wr: 1'b0};
			@(negedge clk);
			check(sound.snd1, ref_snd1, "snd1");
			check(sound.snd2, ref_snd2, "snd2");
		end

		// two latch pulses in 32 cycles
		pulses = 0;
		repeat (32)
		begin
			@(negedge clk);
			if (sx_rclk)
				pulses++;
		end
		check(pulses, 2, "sx_rclk pulse count");

		// one whole frame under the video compare
		repeat (FRAME_CYCLES + 320) @(posedge clk);
		@(negedge clk);

		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== invaders_io.f ====
+incdir+src
src/invaders_io_pkg.sv
src/video_timing.sv
src/io_port_regs.sv
src/mb14241_shifter.sv
src/input_port_mux.sv
src/sound_serializer.sv
src/invaders_io_top.sv
tb/invaders_io_props.sv
tb/invaders_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the invaders i/o testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	-f invaders_io.f \
	--top-module invaders_io_tb

# the run may stop on a failed check, the log decides
./obj_dir/Vinvaders_io_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
